// ==== verification/radar_stimulus.txt ====
# T <has_target> <target_x> <target_y>  opens a frame record
# P <grid_x> <grid_y> <expected_rgb_hex>  probe checked in that frame
T 0 0 0
P 20 150 000000
P 0 32 FF0000
P 0 96 FF0000
P 0 224 FF0000
P -128 100 FF0000
P 128 50 FF0000
P 140 100 000000
P -150 20 000000
P 50 50 FF0000
P -70 70 FF0000
P 64 17 FF0000
P 30 96 000000
P 26 92 FF0000
T 1 30 96
P 30 96 00FF00
P 34 92 00FF00
P 26 92 00FF00
P 36 96 000000
P 35 96 000000
P 0 96 FF0000
P -60 150 000000
P 20 150 000000
T 1 -60 150
P -60 150 00FF00
P -56 146 00FF00
P 30 96 000000
P 26 92 FF0000
P -65 150 000000

// ==== files.f ====
rtl/radar_pkg.sv
rtl/scan_if.sv
rtl/display_timing.sv
rtl/radar_grid.sv
rtl/target_marker.sv
rtl/pixel_compositor.sv
rtl/radar_display_top.sv
verification/radar_display_assert.sv
verification/radar_display_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary -f files.f --top-module radar_display_tb -o radar_sim

out=$(./obj_dir/radar_sim)
echo "$out"

if echo "$out" | grep -q "RESULT: PASS"; then
	exit 0
else
	exit 1
fi

// ==== verification/radar_display_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module radar_display_tb;
	import radar_pkg::*;

	localparam int MAX_RECORDS = 16;
	localparam int MAX_PROBES = 64;

	logic clock;
	logic arst_n;
	logic signed [COORD_W-1:0] target_x;
	logic signed [COORD_W-1:0] target_y;
	logic target_load;
	logic [PIXEL_W-1:0] pixel;
	logic hsync;
	logic vsync;
	logic de;

	// per-frame records from the stimulus file
	int num_rec;
	bit rec_valid [MAX_RECORDS];
	int rec_x [MAX_RECORDS];
	int rec_y [MAX_RECORDS];
	// probe points with the colour they must show
	int num_probe;
	int probe_rec [MAX_PROBES];
	int probe_x [MAX_PROBES];
	int probe_y [MAX_PROBES];
	logic [PIXEL_W-1:0] probe_color [MAX_PROBES];
	bit probe_hit [MAX_PROBES];

	// output raster tracker
	int out_col;
	int out_row;
	int frame_idx;
	logic prev_de;
	logic prev_vsync;
	// hsync pulse tracking
	logic prev_hsync;
	int hsync_len;
	int hsync_count;
	int since_de;
	// run limit
	int cycle_count;
	int cycle_limit;

	radar_display_top u_radar_display_top (
		.clock (clock),
		.arst_n (arst_n),
		.target_x (target_x),
		.target_y (target_y),
		.target_load (target_load),
		.pixel (pixel),
		.hsync (hsync),
		.vsync (vsync),
		.de (de)
	);

	bind radar_display_top radar_display_assert u_display_assert (
		.clock (clock),
		.arst_n (arst_n),
		.pixel (pixel),
		.hsync (hsync),
		.vsync (vsync),
		.de (de)
	);

	always #2 clock = ~clock;

	//////////////////////////////
	// stimulus file
	//////////////////////////////

	task automatic read_stimulus();
		int fd;
		int code;
		int fields;
		int a;
		int b;
		int v;
		logic [PIXEL_W-1:0] c;
		string line;
		fd = $fopen("verification/radar_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			$display("RESULT: FAIL");
			$fatal(1, "no stimulus");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				fields = 3;
				code = $fgets(line, fd);
				// a T line opens a frame record and P lines add probes to it
				if (code > 2 && line[0] == "T") begin
					fields = $sscanf(line.substr(2, line.len() - 1), "%d %d %d", v, a, b);
					rec_valid[num_rec] = (v != 0);
					rec_x[num_rec] = a;
					rec_y[num_rec] = b;
					num_rec++;
				end else if (code > 2 && line[0] == "P" && num_rec > 0) begin
					fields = $sscanf(line.substr(2, line.len() - 1), "%d %d %h", a, b, c);
					probe_rec[num_probe] = num_rec - 1;
					probe_x[num_probe] = a;
					probe_y[num_probe] = b;
					probe_color[num_probe] = c;
					probe_hit[num_probe] = 1'b0;
					num_probe++;
				end
				if (fields != 3) begin
					$display("malformed line in the stimulus file: %s", line);
					$display("RESULT: FAIL");
					$fatal(1, "bad stimulus");
				end
			end
			$fclose(fd);
		end
	endtask

	// one load pulse when the record has a target
	task automatic load_target(input int r);
		if (rec_valid[r]) begin
			@(posedge clock);
			target_x <= COORD_W'(rec_x[r]);
			target_y <= COORD_W'(rec_y[r]);
			target_load <= 1'b1;
			@(posedge clock);
			target_load <= 1'b0;
		end
	endtask

	//////////////////////////////
	// checks
	//////////////////////////////

	task automatic check_pixel(input int rec, input int gx, input int gy);
		for (int i = 0; i < num_probe; i++) begin
			if (probe_rec[i] == rec && probe_x[i] == gx && probe_y[i] == gy) begin
				assert (pixel == probe_color[i]) else begin
					$display("ERROR: %0t ns probe (%0d, %0d) expected %06h got %06h",
						$time, gx, gy, probe_color[i], pixel);
					$display("RESULT: FAIL");
					$fatal(1, "pixel mismatch");
				end
				probe_hit[i] = 1'b1;
			end
		end
	endtask

	// every probe of a record must have been scanned in its frame
	task automatic check_all_hit(input int rec);
		for (int i = 0; i < num_probe; i++) begin
			if (probe_rec[i] == rec) begin
				assert (probe_hit[i]) else begin
					$display("probe (%0d, %0d) of record %0d was never scanned",
						probe_x[i], probe_y[i], rec);
					$display("RESULT: FAIL");
					$fatal(1, "missing probe");
				end
			end
		end
	endtask

	// hsync position after de, pulse width and pulses per frame
	task automatic track_hsync();
		if (hsync && !prev_hsync) begin
			hsync_count = hsync_count + 1;
			// only lines with active video have a de edge to measure from
			if (since_de < H_TOTAL) begin
				assert (since_de == H_SYNC_START - H_ACTIVE) else begin
					$display("ERROR: %0t ns hsync started %0d cycles after de, expected %0d",
						$time, since_de, H_SYNC_START - H_ACTIVE);
					$display("RESULT: FAIL");
					$fatal(1, "hsync position");
				end
			end
		end
		if (!hsync && prev_hsync) begin
			assert (hsync_len == H_SYNC_END - H_SYNC_START) else begin
				$display("ERROR: %0t ns hsync pulse %0d cycles wide, expected %0d",
					$time, hsync_len, H_SYNC_END - H_SYNC_START);
				$display("RESULT: FAIL");
				$fatal(1, "hsync width");
			end
		end
		if (hsync) begin
			hsync_len = hsync_len + 1;
		end else begin
			hsync_len = 0;
		end
		if (de) begin
			since_de = 0;
		end else begin
			since_de = since_de + 1;
		end
		prev_hsync = hsync;
	endtask

	// raster tracker and output checks on the falling edge
	always @(negedge clock) begin
		if (arst_n) begin
			if (vsync && !prev_vsync) begin
				// a full frame carries one hsync per line
				if (frame_idx >= 1) begin
					assert (hsync_count == V_TOTAL) else begin
						$display("ERROR: %0t ns %0d hsync pulses in a frame, expected %0d",
							$time, hsync_count, V_TOTAL);
						$display("RESULT: FAIL");
						$fatal(1, "hsync count");
					end
				end
				if (frame_idx >= 1 && frame_idx <= num_rec) begin
					check_all_hit(frame_idx - 1);
				end
				hsync_count = 0;
				frame_idx = frame_idx + 1;
				out_row = 0;
				out_col = 0;
			end
			if (de) begin
				// no target can be active before the first frame_start
				if (frame_idx == 0) begin
					assert (pixel != TARGET_COLOR) else begin
						$display("ERROR: %0t ns blip shown in the first frame, pixel %06h",
							$time, pixel);
						$display("RESULT: FAIL");
						$fatal(1, "early blip");
					end
				end
				// frame n shows record n-1
				if (frame_idx >= 1 && frame_idx <= num_rec) begin
					check_pixel(frame_idx - 1, out_col - int'(ORIGIN_X),
						int'(ORIGIN_ROW) - out_row);
				end
				out_col = out_col + 1;
			end else if (prev_de) begin
				out_row = out_row + 1;
				out_col = 0;
			end
			track_hsync();
			prev_de = de;
			prev_vsync = vsync;
		end else if (cycle_count > 0) begin
			// outputs idle and black while reset is held
			assert (pixel == BLANK_COLOR && !de && !hsync && !vsync) else begin
				$display("ERROR: %0t ns outputs not idle in reset, pixel %06h de %0b",
					$time, pixel, de);
				$display("RESULT: FAIL");
				$fatal(1, "reset outputs");
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: frames did not complete");
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		clock = 1'b0;
		arst_n = 1'b0;
		target_x = '0;
		target_y = '0;
		target_load = 1'b0;
		num_rec = 0;
		num_probe = 0;
		out_col = 0;
		out_row = 0;
		frame_idx = 0;
		prev_de = 1'b0;
		prev_vsync = 1'b0;
		prev_hsync = 1'b0;
		hsync_len = 0;
		hsync_count = 0;
		since_de = 0;
		cycle_count = 0;
		cycle_limit = 1000;
		read_stimulus();
		cycle_limit = (num_rec + 2) * H_TOTAL * V_TOTAL;
		repeat (16) @(posedge clock);
		arst_n <= 1'b1;
		// record 0 target is loaded in frame 0
		load_target(0);
		for (int r = 1; r < num_rec; r++) begin
			// load once row 0 of the frame before is out
			wait (frame_idx == r && out_row >= 1);
			load_target(r);
		end
		wait (frame_idx == num_rec + 1);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/radar_display_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module radar_display_assert (
	input logic clock,
	input logic arst_n,
	input logic [radar_pkg::PIXEL_W-1:0] pixel,
	input logic hsync,
	input logic vsync,
	input logic de
);
	import radar_pkg::*;

	// length of the current vsync pulse in cycles
	int vsync_len;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			vsync_len <= 0;
		end else if (vsync) begin
			vsync_len <= vsync_len + 1;
		end else begin
			vsync_len <= 0;
		end
	end

	// no active video during sync
	assert property (@(posedge clock) disable iff (!arst_n) !(de && (hsync || vsync)))
		else $error("de high during sync");

	// blanking is black
	assert property (@(posedge clock) disable iff (!arst_n) !de |-> pixel == BLANK_COLOR)
		else $error("pixel not blank outside de");

	// vsync ends on a line boundary
	assert property (@(posedge clock) disable iff (!arst_n)
		$fell(vsync) |-> (vsync_len > 0) && (vsync_len % H_TOTAL == 0))
		else $error("vsync pulse not whole lines");

endmodule

`default_nettype wire

// ==== rtl/radar_display_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module radar_display_top (
	input logic clock,
	input logic arst_n,
	input logic signed [radar_pkg::COORD_W-1:0] target_x,
	input logic signed [radar_pkg::COORD_W-1:0] target_y,
	input logic target_load,
	output logic [radar_pkg::PIXEL_W-1:0] pixel,
	output logic hsync,
	output logic vsync,
	output logic de
);

	// scan position shared by every stage
	scan_if scan ();

	// results four cycles behind the scan
	logic on_grid;
	logic on_target;

	//////////////////////////////
	// input side
	//////////////////////////////

	display_timing u_display_timing (
		.clock (clock),
		.arst_n (arst_n),
		.scan (scan.source)
	);

	//////////////////////////////
	// grid and blip
	//////////////////////////////

	radar_grid u_radar_grid (
		.clock (clock),
		.arst_n (arst_n),
		.scan (scan.sink),
		.on_grid (on_grid)
	);

	target_marker u_target_marker (
		.clock (clock),
		.arst_n (arst_n),
		.scan (scan.sink),
		.target_x (target_x),
		.target_y (target_y),
		.target_load (target_load),
		.on_target (on_target)
	);

	//////////////////////////////
	// output side
	//////////////////////////////

	pixel_compositor u_pixel_compositor (
		.clock (clock),
		.arst_n (arst_n),
		.scan (scan.sink),
		.on_grid (on_grid),
		.on_target (on_target),
		.pixel (pixel),
		.hsync (hsync),
		.vsync (vsync),
		.de (de)
	);

endmodule

`default_nettype wire

// ==== rtl/pixel_compositor.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_compositor (
	input logic clock,
	input logic arst_n,
	scan_if.sink scan,
	input logic on_grid,
	input logic on_target,
	output logic [radar_pkg::PIXEL_W-1:0] pixel,
	output logic hsync,
	output logic vsync,
	output logic de
);
	import radar_pkg::*;

	// sync delayed to match the grid and marker pipelines
	sync_t sync_pipe [GRID_LATENCY];
	sync_t sync_late;
	logic [PIXEL_W-1:0] color;

	//////////////////////////////
	// sync delay line
	//////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < GRID_LATENCY; i++) begin
				sync_pipe[i] <= '0;
			end
		end else begin
			sync_pipe[0] <= scan.sync;
			for (int i = 1; i < GRID_LATENCY; i++) begin
				sync_pipe[i] <= sync_pipe[i-1];
			end
		end
	end

	assign sync_late = sync_pipe[GRID_LATENCY-1];

	// target over grid over background, black outside the active area
	always_comb begin
		if (!sync_late.de) begin
			color = BLANK_COLOR;
		end else if (on_target) begin
			color = TARGET_COLOR;
		end else if (on_grid) begin
			color = GRID_COLOR;
		end else begin
			color = BLANK_COLOR;
		end
	end

	// output register keeps pixel and sync aligned
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pixel <= BLANK_COLOR;
			hsync <= 1'b0;
			vsync <= 1'b0;
			de <= 1'b0;
		end else begin
			pixel <= color;
			hsync <= sync_late.hsync;
			vsync <= sync_late.vsync;
			de <= sync_late.de;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/target_marker.sv ====
`timescale 1ns/1ns
`default_nettype none

module target_marker (
	input logic clock,
	input logic arst_n,
	scan_if.sink scan,
	input logic signed [radar_pkg::COORD_W-1:0] target_x,
	input logic signed [radar_pkg::COORD_W-1:0] target_y,
	input logic target_load,
	output logic on_target
);
	import radar_pkg::*;

	// loaded target waiting for the next frame
	coord_t pend_x;
	coord_t pend_y;
	logic pend_valid;
	// target shown in the current frame
	coord_t act_x;
	coord_t act_y;
	logic act_valid;
	// target seen by the current pixel, includes the swap on frame_start
	coord_t cur_x;
	coord_t cur_y;
	logic cur_valid;
	logic swap;
	// blip test pipeline
	logic signed [DIFF_W-1:0] dx1;
	logic signed [DIFF_W-1:0] dy1;
	logic signed [DIFF_W-1:0] adx2;
	logic signed [DIFF_W-1:0] ady2;
	logic in_x3;
	logic in_y3;
	logic [2:0] valid_pipe;

	//////////////////////////////
	// frame-synchronous target
	//////////////////////////////

	assign swap = scan.frame_start && pend_valid;
	assign cur_x = swap ? pend_x : act_x;
	assign cur_y = swap ? pend_y : act_y;
	assign cur_valid = swap || act_valid;

	// coordinates are payload
	always_ff @(posedge clock) begin
		if (target_load) begin
			pend_x <= target_x;
			pend_y <= target_y;
		end
		if (swap) begin
			act_x <= pend_x;
			act_y <= pend_y;
		end
	end

	// a later load overwrites, a load on frame_start waits a frame
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pend_valid <= 1'b0;
			act_valid <= 1'b0;
		end else begin
			if (target_load) begin
				pend_valid <= 1'b1;
			end else if (scan.frame_start) begin
				pend_valid <= 1'b0;
			end
			if (swap) begin
				act_valid <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// blip hit test
	//////////////////////////////

	always_ff @(posedge clock) begin
		// stage 1 signed offsets
		dx1 <= DIFF_W'(scan.x_value) - DIFF_W'(cur_x);
		dy1 <= DIFF_W'(scan.y_value) - DIFF_W'(cur_y);
		// stage 2 magnitudes
		adx2 <= dx1[DIFF_W-1] ? -dx1 : dx1;
		ady2 <= dy1[DIFF_W-1] ? -dy1 : dy1;
		// stage 3 window per axis
		in_x3 <= adx2 <= DIFF_W'(BLIP_HALF);
		in_y3 <= ady2 <= DIFF_W'(BLIP_HALF);
	end

	// active flag rides along, stage 4 combines
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_pipe <= '0;
			on_target <= 1'b0;
		end else begin
			valid_pipe <= {valid_pipe[1:0], cur_valid};
			on_target <= valid_pipe[2] && in_x3 && in_y3;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/radar_grid.sv ====
`timescale 1ns/1ns
`default_nettype none

module radar_grid (
	input logic clock,
	input logic arst_n,
	scan_if.sink scan,
	output logic on_grid
);
	import radar_pkg::*;

	// true when diff lies within +-half
	function automatic logic near_line(input logic signed [TEST_W-1:0] diff, input int half);
		logic signed [TEST_W-1:0] lim;
		lim = TEST_W'(half);
		return (diff <= lim) && (diff >= -lim);
	endfunction

	// squared radius against ring k with its tolerance band
	function automatic logic near_ring(input logic signed [SQ_W-1:0] r_sq, input int k);
		logic signed [SQ_W-1:0] radius_sq;
		logic signed [SQ_W-1:0] tol;
		logic signed [SQ_W-1:0] diff;
		radius_sq = SQ_W'(k * k * RING_STEP * RING_STEP);
		// inner ring tight, outer rings looser
		if (k == 1) begin
			tol = SQ_W'(LINE_WIDTH * RING_TOL_NEAR);
		end else if (k <= 4) begin
			tol = SQ_W'(LINE_WIDTH * RING_TOL_MID);
		end else begin
			tol = SQ_W'(LINE_WIDTH * RING_TOL_FAR);
		end
		diff = r_sq - radius_sq;
		return (diff <= tol) && (diff >= -tol);
	endfunction

	// stage 1
	coord_t x_e;
	coord_t y_e;
	logic on_border1;
	logic out_border1;
	// stage 2
	logic signed [TEST_W-1:0] test_15;
	logic signed [TEST_W-1:0] test_45;
	logic signed [TEST_W-1:0] test_75;
	logic signed [SQ_W-1:0] r_sq;
	coord_t y_e2;
	logic on_border2;
	logic out_border2;
	// stage 3
	logic signed [TEST_W-1:0] y_wide;
	logic ring_any;
	logic on_ring3;
	logic [5:0] on_line3;
	logic on_border3;
	logic out_border3;

	//////////////////////////////
	// stage 3 combinational part
	//////////////////////////////

	assign y_wide = TEST_W'(y_e2);

	always_comb begin
		ring_any = 1'b0;
		for (int k = 1; k <= RING_COUNT; k++) begin
			ring_any = ring_any | near_ring(r_sq, k);
		end
	end

	//////////////////////////////
	// data pipeline
	//////////////////////////////

	always_ff @(posedge clock) begin
		// stage 1 effective coordinates, border band and clip flag
		x_e <= scan.x_value;
		y_e <= scan.y_value - BORDER_BOTTOM;
		on_border1 <= (scan.x_value >= BORDER_RIGHT) || (scan.x_value <= BORDER_LEFT) ||
			(scan.y_value >= BORDER_TOP) || (scan.y_value <= BORDER_BOTTOM);
		out_border1 <= (scan.x_value > BORDER_RIGHT + BORDER_WIDTH) ||
			(scan.x_value < BORDER_LEFT - BORDER_WIDTH) ||
			(scan.y_value > BORDER_TOP + BORDER_WIDTH) ||
			(scan.y_value < BORDER_BOTTOM - BORDER_WIDTH);

		// stage 2 x*tan(angle) and squared radius
		test_15 <= TEST_W'((x_e * TAN15_NUM) >>> TAN_SHIFT);
		// tan 45 is exactly one
		test_45 <= TEST_W'(x_e);
		test_75 <= TEST_W'((x_e * TAN75_NUM) >>> TAN_SHIFT);
		r_sq <= SQ_W'(x_e) * SQ_W'(x_e) + SQ_W'(y_e) * SQ_W'(y_e);
		y_e2 <= y_e;
		on_border2 <= on_border1;
		out_border2 <= out_border1;

		// stage 3 line windows, the negative side uses tan(180-a) = -tan(a)
		on_line3[0] <= near_line(test_15 - y_wide, LINE_WIDTH);
		on_line3[1] <= near_line(test_15 + y_wide, LINE_WIDTH);
		on_line3[2] <= near_line(test_45 - y_wide, LINE_WIDTH);
		on_line3[3] <= near_line(test_45 + y_wide, LINE_WIDTH);
		// steep lines round badly so widen them
		on_line3[4] <= near_line(test_75 - y_wide, LINE_WIDTH * STEEP_TOL);
		on_line3[5] <= near_line(test_75 + y_wide, LINE_WIDTH * STEEP_TOL);
		on_ring3 <= ring_any;
		on_border3 <= on_border2;
		out_border3 <= out_border2;
	end

	// stage 4 final decision
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			on_grid <= 1'b0;
		end else begin
			on_grid <= !out_border3 && (on_border3 || on_ring3 || (|on_line3));
		end
	end

endmodule

`default_nettype wire

// ==== rtl/display_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module display_timing (
	input logic clock,
	input logic arst_n,
	scan_if.source scan
);
	import radar_pkg::*;

	// raster position
	logic [H_CNT_W-1:0] col;
	logic [V_CNT_W-1:0] row;
	// position for the next cycle
	logic [H_CNT_W-1:0] col_next;
	logic [V_CNT_W-1:0] row_next;
	sync_t sync_next;

	//////////////////////////////
	// counters
	//////////////////////////////

	// column wraps at the line end and then bumps the row
	always_comb begin
		col_next = col + 1'b1;
		row_next = row;
		if (int'(col) == H_TOTAL - 1) begin
			col_next = '0;
			if (int'(row) == V_TOTAL - 1) begin
				row_next = '0;
			end else begin
				row_next = row + 1'b1;
			end
		end
	end

	// flags decoded from the next position so they register with it
	always_comb begin
		sync_next.de = (int'(col_next) < H_ACTIVE) && (int'(row_next) < V_ACTIVE);
		sync_next.hsync = (int'(col_next) >= H_SYNC_START) && (int'(col_next) < H_SYNC_END);
		// vsync spans whole lines
		sync_next.vsync = (int'(row_next) >= V_SYNC_START) && (int'(row_next) < V_SYNC_END);
	end

	//////////////////////////////
	// registered scan outputs
	//////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			col <= '0;
			row <= '0;
			// grid position of column 0 row 0
			scan.x_value <= -ORIGIN_X;
			scan.y_value <= ORIGIN_ROW;
			// sync and de held low in reset
			scan.sync <= '0;
			scan.frame_start <= 1'b0;
		end else begin
			col <= col_next;
			row <= row_next;
			// x grows to the right of the origin
			scan.x_value <= coord_t'(col_next) - ORIGIN_X;
			// y grows upward from the bottom row
			scan.y_value <= ORIGIN_ROW - coord_t'(row_next);
			scan.sync <= sync_next;
			scan.frame_start <= (col_next == '0) && (row_next == '0);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/scan_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface scan_if;
	import radar_pkg::*;

	// signed grid position of the current pixel
	coord_t x_value;
	coord_t y_value;
	// hsync, vsync, de for the same pixel
	sync_t sync;
	// high on row 0 column 0 only
	logic frame_start;

	// timing generator drives
	modport source (
		output x_value,
		output y_value,
		output sync,
		output frame_start
	);

	// grid, marker and compositor listen
	modport sink (
		input x_value,
		input y_value,
		input sync,
		input frame_start
	);

endinterface

`default_nettype wire

// ==== rtl/radar_pkg.sv ====
`default_nettype none

package radar_pkg;

	//////////////////////////////
	// raster geometry
	//////////////////////////////

	// visible area
	localparam int H_ACTIVE = 320;
	localparam int V_ACTIVE = 240;
	// full line and frame, short porches for simulation
	localparam int H_TOTAL = 336;
	localparam int V_TOTAL = 248;
	// sync pulses sit inside blanking, active high, end is exclusive
	localparam int H_SYNC_START = 324;
	localparam int H_SYNC_END = 332;
	localparam int V_SYNC_START = 242;
	localparam int V_SYNC_END = 244;
	// raster counter widths
	localparam int H_CNT_W = 9;
	localparam int V_CNT_W = 8;

	//////////////////////////////
	// grid coordinates
	//////////////////////////////

	localparam int COORD_W = 12;
	typedef logic signed [COORD_W-1:0] coord_t;

	// screen column and row of grid point (0,0)
	localparam coord_t ORIGIN_X = 160;
	localparam coord_t ORIGIN_ROW = 239;
	// box edges in grid units
	localparam coord_t BORDER_LEFT = -128;
	localparam coord_t BORDER_RIGHT = 128;
	localparam coord_t BORDER_TOP = 232;
	localparam coord_t BORDER_BOTTOM = 0;
	// border drawn this far outside the box edges
	localparam coord_t BORDER_WIDTH = 3;

	// range rings at RING_STEP, 2*RING_STEP .. RING_COUNT*RING_STEP
	localparam int RING_STEP = 32;
	localparam int RING_COUNT = 7;
	localparam int LINE_WIDTH = 1;
	// squared-radius slack grows with the ring, rounding gets worse outward
	localparam int RING_TOL_NEAR = 64;
	localparam int RING_TOL_MID = 128;
	localparam int RING_TOL_FAR = 256;
	// 75 degree lines need a wider window
	localparam int STEEP_TOL = 3;
	// tangents as numerator over 2**TAN_SHIFT
	localparam int TAN15_NUM = 17;
	localparam int TAN75_NUM = 240;
	localparam int TAN_SHIFT = 6;

	// internal arithmetic widths
	localparam int SQ_W = 2 * COORD_W + 1;
	localparam int TEST_W = COORD_W + 9;
	localparam int DIFF_W = COORD_W + 1;

	// blip covers |dx| and |dy| up to this
	localparam int BLIP_HALF = 4;

	//////////////////////////////
	// colours and pipeline
	//////////////////////////////

	localparam int PIXEL_W = 24;
	localparam logic [PIXEL_W-1:0] BLANK_COLOR = 24'h00_00_00;
	localparam logic [PIXEL_W-1:0] GRID_COLOR = 24'hFF_00_00;
	localparam logic [PIXEL_W-1:0] TARGET_COLOR = 24'h00_FF_00;

	// depth of grid and marker pipelines
	localparam int GRID_LATENCY = 4;

	// sync flags that travel together with a scan position
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} sync_t;

endpackage

`default_nettype wire
